// File: Makefile
TOP := uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/uart_golden.txt
# id mode ctrl byte corrupt exp_err (ctrl, byte and exp_err in hex)
# mode 0 loopback 1 injected 2 fifo fill 3 irq, corrupt 1 parity 2 stop, exp_err {stop,parity}
1 0 00000001 a5 0 0
2 0 00000001 3c 0 0
3 0 00000007 5a 0 0
4 0 00000007 81 0 0
5 0 00000005 e7 0 0
6 1 00000005 96 0 0
7 1 00000005 4b 1 1
8 1 00000005 d2 2 2
9 1 00000007 0f 0 0
10 2 00000001 00 0 0
11 3 00010001 c3 0 0
12 0 00000003 69 0 0

// File: dv/uart_tb.sv
/* UART testbench */

module uart_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    typedef struct packed {
        logic [7:0]  id;
        logic [1:0]  mode;       // 0 loopback, 1 injected, 2 FIFO fill, 3 interrupt
        logic [31:0] ctrl;
        logic [7:0]  data;
        logic [1:0]  corrupt;    // 1 parity flipped, 2 stop bit low
        logic [1:0]  exp_err;    // {stop, parity}
    } vec_t;

    localparam int bit_cycles = 8;   // Scaler 4, two toggles per bit
    localparam int poll_limit = 400;

    logic      i_clk;
    logic      i_nrst;
    bus_req_t  req;
    bus_resp_t resp;
    logic      td;
    logic      irq;
    logic      rd_line;
    logic      rd_drv;
    logic      loopback;

    vec_t        vecs[$];
    string       test_name;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    logic [31:0] lcg_state;

    assign rd_line = loopback ? td : rd_drv;

    uart_top #(.log2_fifo_depth(4)) UUT (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req(req), .i_rd(rd_line),
        .o_resp(resp), .o_td(td), .o_irq(irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        @(negedge i_clk);
        req = '0;
    endtask

    // Response is registered, so it is valid at the next falling edge
    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
        req.valid = 1'b1;
        req.write = 1'b0;
        req.addr  = addr;
        req.wdata = '0;
        @(negedge i_clk);
        req = '0;
        check_val("response valid", 32'd1, {31'd0, resp.valid});
        data = resp.rdata;
    endtask

    task automatic configure(input logic [31:0] tx_word, input logic [31:0] rx_word);
        logic [31:0] rd;
        bus_write(txctrl, tx_word);
        bus_write(rxctrl, rx_word);
        bus_read(txctrl, rd);
        check_val("txctrl", tx_word & 32'h0007_0007, rd);
    endtask

    task automatic send_bit(input logic b);
        rd_drv = b;
        repeat (bit_cycles) @(negedge i_clk);
    endtask

    task automatic send_frame(input logic [7:0] d, input logic par, input logic nstop,
                              input logic [1:0] corrupt);
        int i;
        send_bit(1'b0);
        for (i = 0; i < 8; i++) send_bit(d[i]);
        if (par) send_bit((^d) ^ (corrupt == 2'd1));
        send_bit(corrupt != 2'd2);
        if (nstop) send_bit(1'b1);
        repeat (2) send_bit(1'b1);   // Idle gap
    endtask

    // Poll rxdata, a non-empty read pops the byte
    task automatic recv_byte(output logic [7:0] b, output logic got);
        logic [31:0] rd;
        int          n;
        got = 1'b0;
        b   = '0;
        for (n = 0; n < poll_limit && !got; n++) begin
            bus_read(rxdata, rd);
            if (!rd[31]) begin
                got = 1'b1;
                b   = rd[7:0];
            end
        end
        assert (got) else begin
            $display("%s: no byte arrived on rxdata within %0d polls", test_name, poll_limit);
            err_cnt++;
        end
    endtask

    task automatic check_rxctrl(input vec_t v);
        logic [31:0] rd;
        bus_read(rxctrl, rd);
        check_val("rxctrl", (v.ctrl & 32'h0007_0007) | {27'd0, v.exp_err, 3'd0}, rd);
    endtask

    task automatic test_loopback(input vec_t v);
        logic [7:0]  sent[3];
        logic [7:0]  b;
        logic        got;
        logic [31:0] rd;
        int          i;
        test_name = $sformatf("t%0d_loopback", v.id);
        sent[0]   = v.data;
        sent[1]   = ~v.data;
        sent[2]   = {v.data[3:0], v.data[7:4]};
        loopback  = 1'b1;
        configure(v.ctrl, v.ctrl);
        for (i = 0; i < 3; i++) bus_write(txdata, {24'd0, sent[i]});
        for (i = 0; i < 3; i++) begin
            recv_byte(b, got);
            if (got) check_val($sformatf("byte %0d", i), {24'd0, sent[i]}, {24'd0, b});
        end
        bus_read(rxdata, rd);
        check_val("rxdata empty", 32'd1, {31'd0, rd[31]});
        check_rxctrl(v);
    endtask

    task automatic test_inject(input vec_t v);
        logic [7:0] b;
        logic       got;
        test_name = $sformatf("t%0d_inject", v.id);
        loopback  = 1'b0;
        rd_drv    = 1'b1;
        configure(v.ctrl, v.ctrl);
        send_frame(v.data, v.ctrl[2], v.ctrl[1], v.corrupt);
        recv_byte(b, got);
        if (got) check_val("byte", {24'd0, v.data}, {24'd0, b});
        check_rxctrl(v);
    endtask

    task automatic test_fill(input vec_t v);
        logic [7:0]  sent[16];
        logic [7:0]  b;
        logic        got;
        logic [31:0] rd;
        int          i;
        test_name = $sformatf("t%0d_fifo_fill", v.id);
        loopback  = 1'b1;
        configure(v.ctrl & ~32'h1, v.ctrl);   // Transmitter held off
        for (i = 0; i < 16; i++) begin
            lcg_state = lcg_next(lcg_state);
            sent[i]   = lcg_state[23:16];
            bus_write(txdata, {24'd0, sent[i]});
            bus_read(txdata, rd);
            check_val($sformatf("full after %0d writes", i + 1), {31'd0, i >= 14},
                      {31'd0, rd[31]});
        end
        bus_write(txctrl, v.ctrl);
        for (i = 0; i < 15; i++) begin
            recv_byte(b, got);
            if (got) check_val($sformatf("byte %0d", i), {24'd0, sent[i]}, {24'd0, b});
        end
        repeat (26 * bit_cycles) @(negedge i_clk);   // Room for a 16th frame
        bus_read(rxdata, rd);
        check_val("rxdata empty after 15 bytes", 32'd1, {31'd0, rd[31]});
        check_rxctrl(v);
    endtask

    task automatic test_irq(input vec_t v);
        logic [31:0] rd;
        int          n;
        test_name = $sformatf("t%0d_irq", v.id);
        loopback  = 1'b1;
        configure(v.ctrl, v.ctrl);
        bus_write(ip, 32'd0);
        bus_write(ie, 32'd2);
        bus_write(txdata, {24'd0, v.data});
        bus_write(txdata, {24'd0, ~v.data});
        n = 0;
        while (!irq && n < poll_limit) begin
            @(negedge i_clk);
            n++;
        end
        assert (irq) else begin
            $display("%s: interrupt line never rose", test_name);
            err_cnt++;
        end
        bus_read(ip, rd);
        check_val("ip", 32'd2, rd);
        // Exactly two bytes when the line rises
        bus_read(rxdata, rd);
        check_val("rxdata first", {24'd0, v.data}, rd);
        bus_read(rxdata, rd);
        check_val("rxdata second", {24'd0, ~v.data}, rd);
        bus_read(rxdata, rd);
        check_val("rxdata empty", 32'd1, {31'd0, rd[31]});
        bus_write(ip, 32'd0);
        check_val("o_irq after clear", 32'd0, {31'd0, irq});
        @(negedge i_clk);
        check_val("o_irq one cycle later", 32'd0, {31'd0, irq});
        bus_write(ie, 32'd0);
        check_rxctrl(v);
    endtask

    task automatic finish_test(input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", test_name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        int          errs_before;
        errs_before = err_cnt;
        test_name   = "t0_reset";
        check_val("o_td", 32'd1, {31'd0, td});
        check_val("o_irq", 32'd0, {31'd0, irq});
        check_val("o_resp.valid", 32'd0, {31'd0, resp.valid});
        bus_read(txctrl, rd);
        check_val("txctrl", 32'd0, rd);
        bus_read(scaler, rd);
        check_val("scaler", 32'd0, rd);
        bus_write(scaler, 32'd4);
        bus_read(scaler, rd);
        check_val("scaler", 32'd4, rd);
        finish_test(errs_before);
    endtask

    task automatic run_test(input vec_t v);
        int errs_before;
        errs_before = err_cnt;
        case (v.mode)
            2'd0:    test_loopback(v);
            2'd1:    test_inject(v);
            2'd2:    test_fill(v);
            default: test_irq(v);
        endcase
        finish_test(errs_before);
    endtask

    task automatic load_vectors();
        int    fd;
        int    rc;
        int    n;
        int    id, mode, ctrl, data, corrupt, exp_err;
        string line;
        vec_t  v;
        fd = $fopen("dv/uart_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file dv/uart_golden.txt");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            n  = $sscanf(line, "%d %d %h %h %d %h", id, mode, ctrl, data, corrupt, exp_err);
            if (rc > 0 && n == 6) begin   // Comment lines do not scan
                v.id      = 8'(id);
                v.mode    = 2'(mode);
                v.ctrl    = ctrl;
                v.data    = 8'(data);
                v.corrupt = 2'(corrupt);
                v.exp_err = 2'(exp_err);
                vecs.push_back(v);
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("The golden file holds no tests");
            err_cnt++;
        end
    endtask

    initial begin
        i_nrst    = 1'b0;
        req       = '0;
        rd_drv    = 1'b1;
        loopback  = 1'b0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        lcg_state = 32'd63;
        load_vectors();
        // Four frames of twelve bits per test, the fill test's sixteen, and a margin
        cycle_limit = (vecs.size() * 4 + 16) * 12 * bit_cycles + 2000;
        repeat (16) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        test_reset();
        foreach (vecs[i]) run_test(vecs[i]);
        $display("Tests run %0d: %0d ok, %0d with errors, %0d errors in total",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: source/uart_baud_gen.sv
/* Bit-rate scaler */

module uart_baud_gen (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic [uart_pkg::scaler_w-1:0] i_scaler,
    input  logic                          i_sync_idle,
    output logic                          o_rise,
    output logic                          o_fall
);
    import uart_pkg::*;

    logic [scaler_w-1:0] cnt;
    logic [scaler_w-1:0] scaler_q;   // Last seen value, a change restarts the count
    logic                level;
    logic                tick;

    assign tick = (|i_scaler) && (i_scaler == scaler_q) && !i_sync_idle
                  && (cnt == i_scaler - 1'b1);

    assign o_rise = tick & ~level;
    assign o_fall = tick & level;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt      <= '0;
            scaler_q <= '0;
            level    <= 1'b1;
        end else begin
            scaler_q <= i_scaler;
            if (i_scaler != scaler_q) begin
                cnt <= '0;
            end else if (i_sync_idle) begin
                cnt   <= '0;             // Realign to the next start bit
                level <= 1'b1;
            end else if (tick) begin
                cnt   <= '0;
                level <= ~level;
            end else if (|i_scaler) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: source/uart_fifo.sv
/* Circular byte FIFO */

module uart_fifo #(
    parameter int log2_fifo_depth = 4
) (
    input  logic                                 i_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_we,
    input  logic [uart_pkg::data_w-1:0]          i_wdata,
    input  logic                                 i_re,
    output logic [uart_pkg::data_w-1:0]          o_rdata,
    output uart_pkg::path_status_t               o_status
);
    import uart_pkg::*;

    localparam int depth = 2 ** log2_fifo_depth;

    logic [data_w-1:0]          mem [depth];
    logic [log2_fifo_depth-1:0] wr_ptr;
    logic [log2_fifo_depth-1:0] rd_ptr;
    logic [log2_fifo_depth-1:0] used;
    logic                       full;
    logic                       empty;

    // One slot always left free
    assign full  = (log2_fifo_depth'(wr_ptr + 1'b1) == rd_ptr);
    assign empty = (wr_ptr == rd_ptr);
    assign used  = wr_ptr - rd_ptr;

    assign o_rdata        = mem[rd_ptr];
    assign o_status.full  = full;
    assign o_status.empty = empty;
    assign o_status.count = count_w'(used);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_we) wr_ptr <= wr_ptr + 1'b1;
            if (i_re && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_we) mem[wr_ptr] <= i_wdata;
    end

    // Callers must check full before pushing
    a_no_write_full: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_we |-> !full);

endmodule

// File: source/uart_pkg.sv
/* UART shared types */

package uart_pkg;

    localparam int data_w   = 8;
    localparam int scaler_w = 32;
    localparam int thresh_w = 3;
    localparam int frame_w  = 11;   // Start, data, parity, stop
    localparam int count_w  = 8;    // Occupancy field, depths up to 2**8

    typedef enum logic [2:0] {
        idle,
        start_bit,
        data_bits,
        parity_bit,
        stop_bit
    } uart_state_e;

    // Word offsets of the register port
    typedef enum logic [11:0] {
        txdata = 12'h000,
        rxdata = 12'h004,
        txctrl = 12'h008,
        rxctrl = 12'h00c,
        ie     = 12'h010,
        ip     = 12'h014,
        scaler = 12'h018
    } reg_addr_e;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [11:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } bus_resp_t;

    typedef struct packed {
        logic                ena;
        logic                nstop;    // Two stop bits
        logic                par;
        logic [thresh_w-1:0] irq_thresh;
    } line_cfg_t;

    typedef struct packed {
        logic               full;
        logic               empty;
        logic [count_w-1:0] count;
    } path_status_t;

endpackage

// File: source/uart_regs.sv
/* UART register block */

module uart_regs #(
    parameter int log2_fifo_depth = 4
) (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  uart_pkg::bus_req_t            i_req,
    output uart_pkg::bus_resp_t           o_resp,
    input  uart_pkg::path_status_t        i_tx_status,
    input  uart_pkg::path_status_t        i_rx_status,
    input  logic [uart_pkg::data_w-1:0]   i_rx_data,
    input  logic                          i_err_parity,
    input  logic                          i_err_stop,
    output uart_pkg::line_cfg_t           o_tx_cfg,
    output uart_pkg::line_cfg_t           o_rx_cfg,
    output logic                          o_tx_push,
    output logic [uart_pkg::data_w-1:0]   o_tx_data,
    output logic                          o_rx_pop,
    output logic [uart_pkg::scaler_w-1:0] o_scaler,
    output logic                          o_irq
);
    import uart_pkg::*;

    reg_addr_e                  addr;
    logic                       wr;
    logic                       rd;
    logic [31:0]                rdata;
    logic                       tx_ie, rx_ie;
    logic                       tx_ip, rx_ip;
    logic                       resp_valid;
    logic [31:0]                resp_rdata;
    logic [log2_fifo_depth-1:0] tx_used, rx_used;
    logic                       tx_below, rx_above;

    function automatic logic [31:0] cfg_word(input line_cfg_t cfg);
        logic [31:0] w;
        w = '0;
        w[0] = cfg.ena;
        w[1] = cfg.nstop;
        w[2] = cfg.par;
        w[16 +: thresh_w] = cfg.irq_thresh;
        return w;
    endfunction

    function automatic line_cfg_t word_cfg(input logic [31:0] w);
        line_cfg_t cfg;
        cfg.ena        = w[0];
        cfg.nstop      = w[1];
        cfg.par        = w[2];
        cfg.irq_thresh = w[16 +: thresh_w];
        return cfg;
    endfunction

    assign addr = reg_addr_e'(i_req.addr);
    assign wr   = i_req.valid && i_req.write;
    assign rd   = i_req.valid && !i_req.write;

    assign o_tx_push = wr && (addr == txdata) && !i_tx_status.full;   // Dropped when full
    assign o_tx_data = i_req.wdata[data_w-1:0];
    assign o_rx_pop  = rd && (addr == rxdata) && !i_rx_status.empty;

    assign tx_used  = i_tx_status.count[log2_fifo_depth-1:0];
    assign rx_used  = i_rx_status.count[log2_fifo_depth-1:0];
    assign tx_below = tx_used < log2_fifo_depth'(o_tx_cfg.irq_thresh);
    assign rx_above = rx_used > log2_fifo_depth'(o_rx_cfg.irq_thresh);

    always_comb begin
        rdata = '0;
        case (addr)
            txdata: rdata[31] = i_tx_status.full;
            rxdata: begin
                rdata[31]         = i_rx_status.empty;
                rdata[data_w-1:0] = i_rx_data;
            end
            txctrl: rdata = cfg_word(o_tx_cfg);
            rxctrl: begin
                rdata    = cfg_word(o_rx_cfg);
                rdata[3] = i_err_parity;
                rdata[4] = i_err_stop;
            end
            ie:      rdata[1:0] = {rx_ie, tx_ie};
            ip:      rdata[1:0] = {rx_ip, tx_ip};
            scaler:  rdata = o_scaler;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tx_cfg   <= '0;
            o_rx_cfg   <= '0;
            tx_ie      <= 1'b0;
            rx_ie      <= 1'b0;
            tx_ip      <= 1'b0;
            rx_ip      <= 1'b0;
            o_scaler   <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= i_req.valid;
            if (wr && (addr == txctrl)) o_tx_cfg <= word_cfg(i_req.wdata);
            if (wr && (addr == rxctrl)) o_rx_cfg <= word_cfg(i_req.wdata);
            if (wr && (addr == ie)) {rx_ie, tx_ie} <= i_req.wdata[1:0];
            if (wr && (addr == scaler)) o_scaler <= i_req.wdata;
            if (wr && (addr == ip)) begin
                {rx_ip, tx_ip} <= i_req.wdata[1:0];   // Software write wins
            end else begin
                if (tx_below) tx_ip <= tx_ie;
                if (rx_above) rx_ip <= rx_ie;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        resp_rdata <= rdata;
    end

    assign o_resp.valid = resp_valid;
    assign o_resp.rdata = resp_rdata;
    assign o_irq        = tx_ip | rx_ip;

endmodule

// File: source/uart_rx.sv
/* UART receive path */

module uart_rx #(
    parameter int log2_fifo_depth = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  uart_pkg::line_cfg_t         i_cfg,
    input  logic                        i_rd,
    input  logic                        i_fall,
    input  logic                        i_pop,
    output logic [uart_pkg::data_w-1:0] o_rdata,
    output uart_pkg::path_status_t      o_status,
    output logic                        o_idle,
    output logic                        o_err_parity,
    output logic                        o_err_stop
);
    import uart_pkg::*;

    uart_state_e       state;
    logic [data_w-1:0] shift;
    logic [2:0]        frame_cnt;
    logic              stop_cnt;
    logic              push;

    uart_fifo #(
        .log2_fifo_depth(log2_fifo_depth)
    ) u_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (push),
        .i_wdata (shift),
        .i_re    (i_pop),
        .o_rdata (o_rdata),
        .o_status(o_status)
    );

    // Last stop bit, byte dropped when full
    assign push   = i_fall && (state == stop_bit) && !stop_cnt && !o_status.full;
    assign o_idle = (state == idle);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= idle;
            shift        <= '0;
            frame_cnt    <= '0;
            stop_cnt     <= 1'b0;
            o_err_parity <= 1'b0;
            o_err_stop   <= 1'b0;
        end else if (i_fall) begin
            case (state)
                idle: begin
                    if (!i_rd && i_cfg.ena) begin   // Start bit seen mid-bit
                        state      <= data_bits;
                        frame_cnt  <= '0;
                        o_err_stop <= 1'b0;
                        if (i_cfg.par) o_err_parity <= 1'b0;
                    end
                end
                data_bits: begin
                    shift <= {i_rd, shift[data_w-1:1]};
                    if (frame_cnt == 3'd7) begin
                        state    <= i_cfg.par ? parity_bit : stop_bit;
                        stop_cnt <= i_cfg.nstop;
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                    end
                end
                parity_bit: begin
                    o_err_parity <= (^shift) != i_rd;
                    state        <= stop_bit;
                end
                stop_bit: begin
                    if (!i_rd) o_err_stop <= 1'b1;   // Any low stop bit flags the frame
                    if (!stop_cnt) state <= idle;
                    else stop_cnt <= 1'b0;
                end
                default: state <= idle;
            endcase
        end
    end

    // Each pushed byte raises the occupancy by one
    a_push_lands: assert property (@(posedge i_clk) disable iff (!i_nrst)
        push && !i_pop |=> o_status.count == $past(o_status.count) + 1'b1);

endmodule

// File: source/uart_top.sv
/* Byte UART top level */

module uart_top #(
    parameter int log2_fifo_depth = 4
) (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  uart_pkg::bus_req_t   i_req,
    input  logic                 i_rd,
    output uart_pkg::bus_resp_t  o_resp,
    output logic                 o_td,
    output logic                 o_irq
);
    import uart_pkg::*;

    line_cfg_t           tx_cfg, rx_cfg;
    path_status_t        tx_status, rx_status;
    logic                tx_push, rx_pop;
    logic [data_w-1:0]   tx_data, rx_data;
    logic [scaler_w-1:0] scaler_val;
    logic                rise, fall;
    logic                tx_idle, rx_idle;
    logic                err_parity, err_stop;

    uart_regs #(.log2_fifo_depth(log2_fifo_depth)) u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req(i_req), .o_resp(o_resp),
        .i_tx_status(tx_status), .i_rx_status(rx_status), .i_rx_data(rx_data),
        .i_err_parity(err_parity), .i_err_stop(err_stop),
        .o_tx_cfg(tx_cfg), .o_rx_cfg(rx_cfg), .o_tx_push(tx_push), .o_tx_data(tx_data),
        .o_rx_pop(rx_pop), .o_scaler(scaler_val), .o_irq(o_irq)
    );

    // Both directions quiet, line high
    uart_baud_gen u_baud (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scaler(scaler_val),
        .i_sync_idle(tx_idle & rx_idle & tx_status.empty & i_rd),
        .o_rise(rise), .o_fall(fall)
    );

    uart_tx #(.log2_fifo_depth(log2_fifo_depth)) u_tx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_cfg(tx_cfg), .i_push(tx_push),
        .i_wdata(tx_data), .i_rise(rise), .o_td(o_td), .o_status(tx_status),
        .o_idle(tx_idle)
    );

    uart_rx #(.log2_fifo_depth(log2_fifo_depth)) u_rx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_cfg(rx_cfg), .i_rd(i_rd), .i_fall(fall),
        .i_pop(rx_pop), .o_rdata(rx_data), .o_status(rx_status), .o_idle(rx_idle),
        .o_err_parity(err_parity), .o_err_stop(err_stop)
    );

endmodule

// File: source/uart_tx.sv
/* UART transmit path */

module uart_tx #(
    parameter int log2_fifo_depth = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  uart_pkg::line_cfg_t         i_cfg,
    input  logic                        i_push,
    input  logic [uart_pkg::data_w-1:0] i_wdata,
    input  logic                        i_rise,
    output logic                        o_td,
    output uart_pkg::path_status_t      o_status,
    output logic                        o_idle
);
    import uart_pkg::*;

    uart_state_e        state;
    logic [frame_w-1:0] shift;
    logic [3:0]         frame_cnt;
    logic               stop_cnt;
    logic [data_w-1:0]  fifo_data;
    logic               pop;
    logic               par_bit;

    uart_fifo #(
        .log2_fifo_depth(log2_fifo_depth)
    ) u_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (i_push),
        .i_wdata (i_wdata),
        .i_re    (pop),
        .o_rdata (fifo_data),
        .o_status(o_status)
    );

    assign pop     = i_rise && (state == idle) && !o_status.empty && i_cfg.ena;
    assign par_bit = i_cfg.par ? ^fifo_data : 1'b1;   // Extra stop bit without parity
    assign o_td    = shift[0];
    assign o_idle  = (state == idle);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= idle;
            shift     <= '1;
            frame_cnt <= '0;
            stop_cnt  <= 1'b0;
        end else if (i_rise) begin
            case (state)
                idle: begin
                    if (pop) begin
                        shift     <= {1'b1, par_bit, fifo_data, 1'b0};
                        state     <= start_bit;
                        frame_cnt <= '0;
                    end
                end
                start_bit: state <= data_bits;
                data_bits: begin
                    if (frame_cnt == 4'd8) begin
                        state    <= i_cfg.par ? parity_bit : stop_bit;
                        stop_cnt <= i_cfg.nstop;
                    end
                end
                parity_bit: state <= stop_bit;
                stop_bit: begin
                    if (!stop_cnt) state <= idle;
                    else stop_cnt <= 1'b0;
                end
                default: state <= idle;
            endcase

            if (state != idle) begin
                frame_cnt <= frame_cnt + 1'b1;
                shift     <= {1'b1, shift[frame_w-1:1]};   // LSB first, ones behind
            end
        end
    end

    a_idle_line_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state == idle) |-> o_td);

endmodule

// File: vlog.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_top.sv
dv/uart_tb.sv
